// File: src/rv_pkg.sv
package rv_pkg;

  // data path and pc width
  localparam int xlen = 64;

  // instruction word width
  localparam int ilen = 32;

  // first fetch address after reset
  localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    op_imm    = 7'b0010011,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_system = 7'b1110011,
    // recognised but never executed
    op_store  = 7'b0100011
  } opcode_e;

  // operation handed from decode to execute
  typedef enum logic [7:0] {
    exu_nop    = 8'h00,
    // plain add of two operands
    exu_add    = 8'h01,
    // add with pc as one operand
    exu_add_pc = 8'h10
  } exu_op_e;

  // fetch unit states
  typedef enum logic [1:0] {
    // bus cycle in progress
    st_fetch = 2'b00,
    // one cycle, writeback and pc update
    st_exec  = 2'b01,
    // parked until reset
    st_halt  = 2'b10
  } fetch_state_e;

endpackage

// File: src/ifu.sv
module ifu
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  // wishbone classic instruction bus, read only
  input  logic            ibus_ack,
  input  logic [ilen-1:0] ibus_dat_rd,
  output logic            ibus_cyc,
  output logic            ibus_stb,
  output logic            ibus_we,
  output logic [xlen-1:0] ibus_adr,
  // from decode and execute
  input  logic [xlen-1:0] next_pc,
  input  logic            rd_we,
  input  logic            ebreak,
  input  logic            invalid,
  // to decode
  output logic [xlen-1:0] pc,
  output logic [ilen-1:0] inst,
  // status
  output logic            rd_commit,
  output logic            retire_valid,
  output logic            halted,
  output logic            illegal
);

  fetch_state_e state;
  logic         cyc_q;
  logic         ack_seen;

  // ack only counts inside our own cycle
  assign ack_seen = cyc_q & ibus_ack;

  // cyc and stb always move together
  assign ibus_cyc = cyc_q;
  assign ibus_stb = cyc_q;
  assign ibus_we  = 1'b0;
  // pc only changes in exec, so address is stable while cyc is high
  assign ibus_adr = pc;

  // exec lasts one cycle, so this is one retire per instruction
  assign retire_valid = (state == st_exec);
  // register write only in the exec cycle
  assign rd_commit = retire_valid & rd_we;
  assign halted = (state == st_halt);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_fetch;
      cyc_q   <= 1'b0;
      pc      <= reset_pc;
      illegal <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          if (ack_seen) begin
            // drop the request in the cycle after ack
            cyc_q <= 1'b0;
            state <= st_exec;
          end else begin
            // first fetch after reset raises cyc here
            cyc_q <= 1'b1;
          end
        end
        st_exec: begin
          pc <= next_pc;
          if (ebreak || invalid) begin
            state   <= st_halt;
            // stays set, halt is only left by reset
            illegal <= invalid;
          end else begin
            state <= st_fetch;
            cyc_q <= 1'b1;
          end
        end
        st_halt: begin
          cyc_q <= 1'b0;
        end
        default: begin
          state <= st_halt;
          cyc_q <= 1'b0;
        end
      endcase
    end
  end

  // instruction register, loaded on the ack edge
  always_ff @(posedge clk) begin
    if (ack_seen) begin
      inst <= ibus_dat_rd;
    end
  end

endmodule

// File: src/idu.sv
module idu
  import rv_pkg::*;
(
  input  logic [xlen-1:0] pc,
  input  logic [ilen-1:0] inst,
  input  logic [xlen-1:0] rs1_data,
  // register file controls
  output logic [4:0]      rs1_addr,
  output logic [4:0]      rs2_addr,
  output logic            rd_we,
  output logic [4:0]      rd_addr,
  // result operands
  output logic [xlen-1:0] op1,
  output logic [xlen-1:0] op2,
  // jump target operands
  output logic [xlen-1:0] op1_jump,
  output logic [xlen-1:0] op2_jump,
  output exu_op_e         exu_op,
  output logic            jump,
  output logic            ebreak,
  output logic            invalid
);

  opcode_e         opcode;
  logic [4:0]      rd;
  logic [2:0]      funct3;
  logic [4:0]      rs1;
  logic [11:0]     imm_i;
  logic [19:0]     imm_uj;
  logic [xlen-1:0] src_i;
  logic [xlen-1:0] src_u;
  logic [xlen-1:0] src_j;
  logic            inst_addi;
  logic            inst_lui;
  logic            inst_auipc;
  logic            inst_jal;
  logic            inst_jalr;
  logic            type_i;
  logic            type_u;
  logic            type_j;

  // instruction fields
  assign opcode = opcode_e'(inst[6:0]);
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign imm_i  = inst[31:20];
  // shared upper field of u and j formats
  assign imm_uj = inst[31:12];

  // sign extended immediates
  assign src_i = {{(xlen-12){imm_i[11]}}, imm_i};
  assign src_u = {{(xlen-32){imm_uj[19]}}, imm_uj, 12'b0};
  // j immediate is scrambled, bit 0 always zero
  assign src_j = {{(xlen-21){imm_uj[19]}}, imm_uj[19], imm_uj[7:0], imm_uj[8],
                  imm_uj[18:9], 1'b0};

  always_comb begin
    inst_addi  = 1'b0;
    inst_lui   = 1'b0;
    inst_auipc = 1'b0;
    inst_jal   = 1'b0;
    inst_jalr  = 1'b0;
    ebreak     = 1'b0;
    case (opcode)
      op_imm:    inst_addi = (funct3 == 3'b000);
      op_lui:    inst_lui = 1'b1;
      op_auipc:  inst_auipc = 1'b1;
      op_jal:    inst_jal = 1'b1;
      op_jalr:   inst_jalr = (funct3 == 3'b000);
      // exact ebreak word, ecall and csr ops fall through
      op_system: ebreak = (inst[31:7] == 25'h0002000);
      // sd decodes to nothing and ends up invalid
      op_store:  ebreak = 1'b0;
      default:   ebreak = 1'b0;
    endcase
  end

  assign invalid = ~(inst_addi | inst_lui | inst_auipc | inst_jal | inst_jalr | ebreak);

  // format classes, ebreak writes nothing so it is left out of type_i
  assign type_i = inst_addi | inst_jalr;
  assign type_u = inst_lui | inst_auipc;
  assign type_j = inst_jal;

  // only i format reads rs1, nothing here reads rs2
  assign rs1_addr = type_i ? rs1 : 5'd0;
  assign rs2_addr = 5'd0;
  assign rd_we    = type_i | type_u | type_j;
  assign rd_addr  = rd_we ? rd : 5'd0;
  assign jump     = inst_jal | inst_jalr;

  // pc relative results use the pc flavoured add
  always_comb begin
    if (inst_addi || inst_lui) begin
      exu_op = exu_add;
    end else if (inst_auipc || jump) begin
      exu_op = exu_add_pc;
    end else begin
      exu_op = exu_nop;
    end
  end

  always_comb begin
    op1      = '0;
    op2      = '0;
    op1_jump = '0;
    op2_jump = '0;
    case ({type_j, type_u, type_i})
      3'b001: begin
        if (inst_jalr) begin
          // link value pc + 4, target rs1 + imm
          op1      = pc;
          op2      = xlen'(4);
          op1_jump = rs1_data;
          op2_jump = src_i;
        end else begin
          op1 = rs1_data;
          op2 = src_i;
        end
      end
      3'b010: begin
        // lui adds to zero, auipc to pc
        op1 = inst_auipc ? pc : '0;
        op2 = src_u;
      end
      3'b100: begin
        op1      = pc;
        op2      = xlen'(4);
        op1_jump = pc;
        op2_jump = src_j;
      end
      default: begin
        op1 = '0;
        op2 = '0;
      end
    endcase
  end

endmodule

// File: src/regfile.sv
module regfile
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic [4:0]      rs1_addr,
  input  logic [4:0]      rs2_addr,
  input  logic            we,
  input  logic [4:0]      rd_addr,
  input  logic [xlen-1:0] rd_data,
  output logic [xlen-1:0] rs1_data,
  output logic [xlen-1:0] rs2_data
);

  // x0 .. x31
  logic [xlen-1:0] regs [32];

  // single write port, visible from the next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd_addr != 5'd0)) begin
      // writes to x0 are dropped
      regs[rd_addr] <= rd_data;
    end
  end

  // combinational read ports
  // x0 forced to zero on the read side as well
  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// File: src/exu.sv
module exu
  import rv_pkg::*;
(
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] op1,
  input  logic [xlen-1:0] op2,
  input  logic [xlen-1:0] op1_jump,
  input  logic [xlen-1:0] op2_jump,
  input  exu_op_e         exu_op,
  input  logic            jump,
  output logic [xlen-1:0] rd_data,
  output logic [xlen-1:0] next_pc
);

  logic [xlen-1:0] sum;
  logic [xlen-1:0] jump_sum;
  logic [xlen-1:0] target;
  logic [xlen-1:0] pc_seq;

  // result adder, also builds the link value
  assign sum = op1 + op2;

  // separate target adder so jal and jalr finish in one cycle
  assign jump_sum = op1_jump + op2_jump;
  // jalr needs bit 0 cleared, harmless for jal
  assign target = {jump_sum[xlen-1:1], 1'b0};

  // sequential pc
  assign pc_seq = pc + xlen'(4);

  always_comb begin
    case (exu_op)
      exu_add:    rd_data = sum;
      exu_add_pc: rd_data = sum;
      // ebreak and invalid words produce nothing
      default:    rd_data = '0;
    endcase
  end

  assign next_pc = jump ? target : pc_seq;

endmodule

// File: src/core_top.sv
module core_top
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  // wishbone classic instruction bus
  input  logic            ibus_ack,
  input  logic [ilen-1:0] ibus_dat_rd,
  output logic            ibus_cyc,
  output logic            ibus_stb,
  output logic            ibus_we,
  output logic [xlen-1:0] ibus_adr,
  // commit trace
  output logic            retire_valid,
  output logic [xlen-1:0] retire_pc,
  output logic [4:0]      retire_rd,
  output logic            retire_we,
  output logic [xlen-1:0] retire_data,
  // status
  output logic            halted,
  output logic            illegal
);

  logic [xlen-1:0] pc;
  logic [ilen-1:0] inst;
  logic [xlen-1:0] next_pc;
  logic [4:0]      rs1_addr;
  logic [4:0]      rs2_addr;
  logic [xlen-1:0] rs1_data;
  logic            rd_we;
  logic [4:0]      rd_addr;
  logic [xlen-1:0] rd_data;
  logic            rd_commit;
  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [xlen-1:0] op1_jump;
  logic [xlen-1:0] op2_jump;
  exu_op_e         exu_op;
  logic            jump;
  logic            ebreak;
  logic            invalid;

  // retire port is the writeback itself
  assign retire_pc   = pc;
  assign retire_rd   = rd_addr;
  assign retire_we   = rd_commit;
  assign retire_data = rd_data;

  ifu u_ifu (
    .clk         (clk),
    .rst         (rst),
    .ibus_ack    (ibus_ack),
    .ibus_dat_rd (ibus_dat_rd),
    .ibus_cyc    (ibus_cyc),
    .ibus_stb    (ibus_stb),
    .ibus_we     (ibus_we),
    .ibus_adr    (ibus_adr),
    .next_pc     (next_pc),
    .rd_we       (rd_we),
    .ebreak      (ebreak),
    .invalid     (invalid),
    .pc          (pc),
    .inst        (inst),
    .rd_commit   (rd_commit),
    .retire_valid(retire_valid),
    .halted      (halted),
    .illegal     (illegal)
  );

  idu u_idu (
    .pc      (pc),
    .inst    (inst),
    .rs1_data(rs1_data),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .rd_we   (rd_we),
    .rd_addr (rd_addr),
    .op1     (op1),
    .op2     (op2),
    .op1_jump(op1_jump),
    .op2_jump(op2_jump),
    .exu_op  (exu_op),
    .jump    (jump),
    .ebreak  (ebreak),
    .invalid (invalid)
  );

  exu u_exu (
    .pc      (pc),
    .op1     (op1),
    .op2     (op2),
    .op1_jump(op1_jump),
    .op2_jump(op2_jump),
    .exu_op  (exu_op),
    .jump    (jump),
    .rd_data (rd_data),
    .next_pc (next_pc)
  );

  // second read port has no user yet
  regfile u_regfile (
    .clk     (clk),
    .rst     (rst),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .we      (rd_commit),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .rs1_data(rs1_data),
    .rs2_data()
  );

endmodule

// File: tb/tb_core.sv
module tb_core
  import rv_pkg::*;
();

  logic            clk;
  logic            rst;
  logic            ibus_ack;
  logic [ilen-1:0] ibus_dat_rd;
  logic            ibus_cyc;
  logic            ibus_stb;
  logic            ibus_we;
  logic [xlen-1:0] ibus_adr;
  logic            retire_valid;
  logic [xlen-1:0] retire_pc;
  logic [4:0]      retire_rd;
  logic            retire_we;
  logic [xlen-1:0] retire_data;
  logic            halted;
  logic            illegal;

  // program memory, word index counted from reset_pc
  logic [31:0]     prog [64];
  logic [31:0]     lcg_state;
  // slave side of the current bus request
  logic            busy;
  int              wait_left;
  logic [xlen-1:0] req_adr;

  // reference model state and its prediction for the next retire
  logic [xlen-1:0] ref_regs [32];
  logic [xlen-1:0] ref_pc;
  logic            exp_we;
  logic [4:0]      exp_rd;
  logic [xlen-1:0] exp_data;
  logic [xlen-1:0] exp_npc;
  logic            exp_halt;
  logic            exp_illegal;

  core_top UUT (
    .clk         (clk),
    .rst         (rst),
    .ibus_ack    (ibus_ack),
    .ibus_dat_rd (ibus_dat_rd),
    .ibus_cyc    (ibus_cyc),
    .ibus_stb    (ibus_stb),
    .ibus_we     (ibus_we),
    .ibus_adr    (ibus_adr),
    .retire_valid(retire_valid),
    .retire_pc   (retire_pc),
    .retire_rd   (retire_rd),
    .retire_we   (retire_we),
    .retire_data (retire_data),
    .halted      (halted),
    .illegal     (illegal)
  );

  always #2 clk = ~clk;

  task automatic report_mismatch(input string msg);
    $display("FAILED at time %0t: %s", $time, msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout: %s", what);
    $display("** FAIL **");
    $fatal(1);
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // unused words, opcode field zero so never a legal instruction
  function automatic logic [31:0] fill_word(input logic [xlen-1:0] adr);
    logic [31:0] fold;
    fold = adr[63:32] ^ adr[31:0];
    return {fold[31:7] ^ {18'b0, fold[6:0]}, 7'b0};
  endfunction

  function automatic logic [31:0] read_word(input logic [xlen-1:0] adr);
    logic [xlen-1:0] off;
    off = adr - reset_pc;
    if (off < 256 && off[1:0] == 2'b00) begin
      return prog[off[7:2]];
    end
    return fill_word(adr);
  endfunction

  // instruction encoders
  function automatic logic [31:0] enc_itype(input opcode_e op, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, op};
  endfunction

  function automatic logic [31:0] enc_utype(input opcode_e op, input logic [4:0] rd,
                                            input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  function automatic logic [31:0] enc_sd(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_ebreak();
    return 32'h0010_0073;
  endfunction

  // wishbone classic slave, 0 to 3 wait cycles per request
  always @(negedge clk) begin
    logic [31:0] r;
    if (rst) begin
      ibus_ack = 1'b0;
      busy = 1'b0;
    end else if (ibus_ack) begin
      // single beat, drop after the ack edge
      ibus_ack = 1'b0;
      busy = 1'b0;
    end else if (ibus_cyc) begin
      assert (ibus_stb && !ibus_we)
        else report_mismatch("bus request with stb low or we high");
      if (!busy) begin
        r = next_rand();
        busy = 1'b1;
        wait_left = r[17:16];
        req_adr = ibus_adr;
      end
      assert (ibus_adr === req_adr)
        else report_mismatch($sformatf("ibus_adr moved to %h during request", ibus_adr));
      if (wait_left == 0) begin
        ibus_ack = 1'b1;
        ibus_dat_rd = read_word(ibus_adr);
      end else begin
        wait_left--;
      end
    end
  end

  task automatic clear_program();
    for (int i = 0; i < 64; i++) begin
      prog[i] = fill_word(reset_pc + xlen'(i) * 4);
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (16) @(negedge clk);
    assert (!ibus_cyc && !ibus_stb && !retire_valid && !halted && !illegal)
      else report_mismatch("outputs not idle during reset");
    rst = 1'b0;
    ref_pc = reset_pc;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    @(negedge clk);
    // first fetch starts the cycle after release
    assert (ibus_cyc && ibus_stb && ibus_adr === reset_pc)
      else report_mismatch("no fetch from reset_pc after reset");
  endtask

  // expected effect of the word at ref_pc, from the instruction set rules
  task automatic predict_step();
    logic [31:0]     w;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] src1;
    w = read_word(ref_pc);
    imm_i = {{52{w[31]}}, w[31:20]};
    imm_u = {{32{w[31]}}, w[31:12], 12'b0};
    imm_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    src1 = ref_regs[w[19:15]];
    exp_we = 1'b1;
    exp_rd = w[11:7];
    exp_data = '0;
    exp_npc = ref_pc + 4;
    exp_halt = 1'b0;
    exp_illegal = 1'b0;
    if (w[6:0] == op_imm && w[14:12] == 3'b000) begin
      exp_data = src1 + imm_i;
    end else if (w[6:0] == op_lui) begin
      exp_data = imm_u;
    end else if (w[6:0] == op_auipc) begin
      exp_data = ref_pc + imm_u;
    end else if (w[6:0] == op_jal) begin
      exp_data = ref_pc + 4;
      exp_npc = ref_pc + imm_j;
    end else if (w[6:0] == op_jalr && w[14:12] == 3'b000) begin
      exp_data = ref_pc + 4;
      exp_npc = (src1 + imm_i) & ~64'd1;
    end else begin
      // ebreak or anything unknown ends the run without a write
      exp_we = 1'b0;
      exp_halt = 1'b1;
      exp_illegal = (w != enc_ebreak());
    end
  endtask

  task automatic check_next_retire();
    int waited;
    waited = 0;
    while (!retire_valid && waited < 30) begin
      @(negedge clk);
      waited++;
    end
    if (!retire_valid) begin
      abort_on_timeout("no instruction retired within 30 cycles");
    end
    predict_step();
    assert (retire_pc === ref_pc)
      else report_mismatch($sformatf("retire_pc %h, expected %h", retire_pc, ref_pc));
    assert (retire_we === exp_we)
      else report_mismatch($sformatf("retire_we %b at pc %h", retire_we, ref_pc));
    if (exp_we) begin
      assert (retire_rd === exp_rd)
        else report_mismatch($sformatf("retire_rd %0d, expected %0d", retire_rd, exp_rd));
      assert (retire_data === exp_data)
        else report_mismatch($sformatf("x%0d data %h, expected %h",
                                       exp_rd, retire_data, exp_data));
      if (exp_rd != 5'd0) begin
        ref_regs[exp_rd] = exp_data;
      end
    end
    ref_pc = exp_npc;
    @(negedge clk);
    assert (!retire_valid)
      else report_mismatch("retire_valid high for more than one cycle");
    assert (halted === exp_halt && illegal === exp_illegal)
      else report_mismatch($sformatf("halted %b illegal %b after pc %h",
                                     halted, illegal, retire_pc));
  endtask

  task automatic run_program(input string name, input logic expect_illegal);
    int steps;
    $display("running %s", name);
    apply_reset();
    steps = 0;
    exp_halt = 1'b0;
    while (!exp_halt && steps < 32) begin
      check_next_retire();
      steps++;
    end
    if (!exp_halt) begin
      abort_on_timeout("program did not halt within 32 instructions");
    end
    assert (illegal === expect_illegal)
      else report_mismatch($sformatf("%s halted with illegal %b", name, illegal));
    // parked until reset, no bus cycle at all
    repeat (50) begin
      @(negedge clk);
      assert (!ibus_cyc && halted && !retire_valid)
        else report_mismatch("bus cycle or retire after halt");
    end
  endtask

  task automatic test_addi_chain();
    clear_program();
    prog[0] = enc_itype(op_imm, 5'd1, 5'd0, 12'd5);
    prog[1] = enc_itype(op_imm, 5'd2, 5'd1, -3);
    // write to x0 is dropped
    prog[2] = enc_itype(op_imm, 5'd0, 5'd1, 12'd7);
    prog[3] = enc_itype(op_imm, 5'd3, 5'd0, -1);
    prog[4] = enc_itype(op_imm, 5'd4, 5'd2, -2048);
    prog[5] = enc_itype(op_imm, 5'd5, 5'd4, 12'd2047);
    prog[6] = enc_ebreak();
    run_program("addi chain", 1'b0);
  endtask

  task automatic test_lui_auipc();
    clear_program();
    prog[0] = enc_utype(op_lui, 5'd1, 20'h12345);
    // sign bit set, upper word all ones
    prog[1] = enc_utype(op_lui, 5'd2, 20'h80000);
    prog[2] = enc_utype(op_auipc, 5'd3, 20'h00001);
    prog[3] = enc_utype(op_auipc, 5'd4, 20'hfffff);
    prog[4] = enc_itype(op_imm, 5'd5, 5'd1, 12'h678);
    prog[5] = enc_ebreak();
    run_program("lui and auipc", 1'b0);
  endtask

  task automatic test_jal();
    clear_program();
    prog[0] = enc_jal(5'd1, 21'd16);
    prog[1] = enc_ebreak();
    prog[4] = enc_itype(op_imm, 5'd5, 5'd1, 12'd0);
    // backward jump, link discarded in x0
    prog[5] = enc_jal(5'd0, -16);
    run_program("jal", 1'b0);
  endtask

  task automatic test_jalr();
    clear_program();
    prog[0] = enc_utype(op_auipc, 5'd1, 20'h0);
    prog[1] = enc_itype(op_imm, 5'd1, 5'd1, 12'd17);
    // odd sums, bit 0 has to be cleared
    prog[2] = enc_itype(op_jalr, 5'd2, 5'd1, 12'd4);
    prog[5] = enc_itype(op_imm, 5'd3, 5'd2, 12'd0);
    prog[6] = enc_itype(op_jalr, 5'd4, 5'd1, 12'd16);
    prog[8] = enc_ebreak();
    run_program("jalr", 1'b0);
  endtask

  task automatic test_ebreak();
    clear_program();
    prog[0] = enc_itype(op_imm, 5'd1, 5'd0, 12'd3);
    prog[1] = enc_ebreak();
    run_program("ebreak", 1'b0);
  endtask

  task automatic test_invalid();
    clear_program();
    prog[0] = enc_itype(op_imm, 5'd1, 5'd0, 12'd8);
    prog[1] = enc_sd(5'd1, 5'd1, 12'd8);
    run_program("sd word", 1'b1);
    clear_program();
    prog[0] = enc_itype(op_imm, 5'd2, 5'd0, 12'd1);
    prog[1] = 32'h0;
    run_program("all zero word", 1'b1);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    ibus_ack = 1'b0;
    ibus_dat_rd = '0;
    busy = 1'b0;
    wait_left = 0;
    req_adr = '0;
    lcg_state = 32'd29511;
    test_addi_chain();
    test_lui_auipc();
    test_jal();
    test_jalr();
    test_ebreak();
    test_invalid();
    $display("** PASS **");
    $finish;
  end

endmodule

// File: compile.f
src/rv_pkg.sv
src/ifu.sv
src/idu.sv
src/regfile.sv
src/exu.sv
src/core_top.sv
tb/tb_core.sv

// File: Bender.yml
package:
  name: rv64i_core

sources:
  - src/rv_pkg.sv
  - src/ifu.sv
  - src/idu.sv
  - src/regfile.sv
  - src/exu.sv
  - src/core_top.sv
  - target: test
    files:
      - tb/tb_core.sv
